// File: hw/spi_bridge_pkg.sv
// spi bridge shared definitions
package spi_bridge_pkg;

	// ------------------------------------------------------------------------
	// receive fifo entry
	// ------------------------------------------------------------------------
	// first marks the first byte after chip select fell
	typedef struct packed {
		logic       first;
		logic [7:0] data;
	} rx_entry_t;

	// sent on miso when the transmit fifo runs dry
	localparam logic [7:0] IDLE_BYTE = 8'hFF;

	// ------------------------------------------------------------------------
	// register map
	// ------------------------------------------------------------------------
	// write only, pushes one byte
	localparam logic [3:0] REG_TXDATA = 4'h0;
	// read pops one entry
	localparam logic [3:0] REG_RXDATA = 4'h4;
	// levels and sticky flags, write one to clear
	localparam logic [3:0] REG_STATUS = 4'h8;

	// status flag positions
	localparam int STAT_UNDERRUN = 16;
	localparam int STAT_OVERFLOW = 17;

	// axi response codes
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// File: hw/spi_edge_if.sv
// spi pin event bus
`timescale 1ns/1ns

interface spi_edge_if;

	// one cycle pulse when chip select goes low
	logic csn_fall;
	// sck edges, only while selected
	logic sck_rise;
	logic sck_fall;
	// synchronized mosi level
	logic mosi_s;
	// chip select active
	logic selected;

	modport src (
		output csn_fall, sck_rise, sck_fall, mosi_s, selected
	);

	modport dst (
		input csn_fall, sck_rise, sck_fall, mosi_s, selected
	);

endinterface

// File: hw/spi_pin_sync.sv
// spi pin synchronizer
`timescale 1ns/1ns

module spi_pin_sync (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       spi_csn,
	input  logic       spi_sck,
	input  logic       spi_mosi,
	spi_edge_if.src    edge_o
);

	logic [1:0] csn_sync;
	logic [1:0] sck_sync;
	logic [1:0] mosi_sync;
	logic       csn_d;
	logic       sck_d;
	logic       mosi_d;
	logic       csn_fall_r;
	logic       sck_rise_r;
	logic       sck_fall_r;

	// two flop synchronizers, csn idles high
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			csn_sync  <= 2'b11;
			sck_sync  <= 2'b00;
			mosi_sync <= 2'b00;
		end else begin
			csn_sync  <= {csn_sync[0], spi_csn};
			sck_sync  <= {sck_sync[0], spi_sck};
			mosi_sync <= {mosi_sync[0], spi_mosi};
		end
	end

	// ------------------------------------------------------------------------
	// edge capture
	// ------------------------------------------------------------------------
	// pulses and delayed levels line up in the same cycle
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			csn_d      <= 1'b1;
			sck_d      <= 1'b0;
			mosi_d     <= 1'b0;
			csn_fall_r <= 1'b0;
			sck_rise_r <= 1'b0;
			sck_fall_r <= 1'b0;
		end else begin
			csn_d      <= csn_sync[1];
			sck_d      <= sck_sync[1];
			mosi_d     <= mosi_sync[1];
			csn_fall_r <= csn_d & ~csn_sync[1];
			sck_rise_r <= ~sck_d & sck_sync[1] & ~csn_sync[1];
			sck_fall_r <= sck_d & ~sck_sync[1] & ~csn_sync[1];
		end
	end

	assign edge_o.csn_fall = csn_fall_r;
	assign edge_o.sck_rise = sck_rise_r;
	assign edge_o.sck_fall = sck_fall_r;
	assign edge_o.mosi_s   = mosi_d;
	assign edge_o.selected = ~csn_d;

endmodule

// File: hw/sync_fifo.sv
// single clock fifo
`timescale 1ns/1ns

module sync_fifo #(
	parameter int  DEPTH     = 8,
	parameter type payload_t = logic [7:0]
) (
	input  logic                       clk_sys,
	input  logic                       rst_n,
	input  logic                       wr_en,
	input  payload_t                   wr_data,
	input  logic                       rd_en,
	output payload_t                   rd_data,
	output logic                       full,
	output logic                       empty,
	output logic [$clog2(DEPTH+1)-1:0] level
);

	localparam int AW = $clog2(DEPTH);
	localparam int LW = $clog2(DEPTH + 1);

	payload_t        mem [DEPTH];
	logic [AW-1:0]   wr_ptr;
	logic [AW-1:0]   rd_ptr;
	logic [LW-1:0]   count;
	logic            do_wr;
	logic            do_rd;

	// writes while full and reads while empty are ignored
	assign do_wr = wr_en & ~full;
	assign do_rd = rd_en & ~empty;

	always_ff @(posedge clk_sys) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	// pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (do_wr && !do_rd) begin
				count <= count + 1'b1;
			end else if (do_rd && !do_wr) begin
				count <= count - 1'b1;
			end
		end
	end

	// head is visible without a read strobe
	assign rd_data = mem[rd_ptr];
	assign full    = (count == LW'(DEPTH));
	assign empty   = (count == '0);
	assign level   = count;

endmodule

// File: hw/spi_tx_serializer.sv
// spi transmit serializer
`timescale 1ns/1ns

module spi_tx_serializer import spi_bridge_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	spi_edge_if.dst    edge_i,
	input  logic [7:0] fifo_data,
	input  logic       fifo_empty,
	output logic       fifo_rd,
	output logic       underrun_evt,
	output logic       spi_miso
);

	logic [2:0] cnt;
	logic [7:0] lock;
	logic       from_fifo;
	logic       load;
	logic       load_dly;
	logic       commit;
	logic       miso;

	// bit counter, idle at zero while deselected
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= 3'd0;
		end else if (!edge_i.selected) begin
			cnt <= 3'd0;
		end else if (edge_i.sck_rise) begin
			cnt <= cnt + 3'd1;
		end
	end

	// ------------------------------------------------------------------------
	// byte lock
	// ------------------------------------------------------------------------
	// peek at the head at frame start and at each byte boundary
	assign load = edge_i.csn_fall | (edge_i.sck_fall & (cnt == 3'd0));

	always_ff @(posedge clk_sys) begin
		if (load) begin
			lock <= fifo_empty ? IDLE_BYTE : fifo_data;
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			from_fifo <= 1'b0;
			load_dly  <= 1'b0;
		end else begin
			load_dly <= load;
			if (load) begin
				from_fifo <= ~fifo_empty;
			end
		end
	end

	// the byte only counts once the master clocks its first bit,
	// so a lock at the last fall of a frame loses nothing
	assign commit       = edge_i.sck_rise & (cnt == 3'd0);
	assign fifo_rd      = commit & from_fifo;
	assign underrun_evt = commit & ~from_fifo;

	// ------------------------------------------------------------------------
	// miso output
	// ------------------------------------------------------------------------
	// msb right after a load, the rest on sck fall
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			miso <= 1'b1;
		end else if (load_dly) begin
			miso <= lock[7];
		end else if (edge_i.sck_fall && cnt != 3'd0) begin
			miso <= lock[3'd7 - cnt];
		end
	end

	assign spi_miso = miso;

endmodule

// File: hw/spi_rx_deserializer.sv
// spi receive deserializer
`timescale 1ns/1ns

module spi_rx_deserializer import spi_bridge_pkg::*; (
	input  logic      clk_sys,
	input  logic      rst_n,
	spi_edge_if.dst   edge_i,
	input  logic      fifo_full,
	output logic      fifo_wr,
	output rx_entry_t fifo_data,
	output logic      overflow_evt
);

	logic [2:0] cnt;
	logic [6:0] shift;
	logic       first_pending;
	logic       done;

	// eighth rising edge completes a byte
	assign done = edge_i.sck_rise & (cnt == 3'd7);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cnt           <= 3'd0;
			first_pending <= 1'b0;
		end else begin
			if (!edge_i.selected) begin
				cnt <= 3'd0;
			end else if (edge_i.sck_rise) begin
				cnt <= cnt + 3'd1;
			end
			// the first byte of a frame is flagged, dropped or not
			if (edge_i.csn_fall) begin
				first_pending <= 1'b1;
			end else if (done) begin
				first_pending <= 1'b0;
			end
		end
	end

	// only seven bits are held, the last one comes straight from the pin
	always_ff @(posedge clk_sys) begin
		if (edge_i.sck_rise) begin
			shift <= {shift[5:0], edge_i.mosi_s};
		end
	end

	// ------------------------------------------------------------------------
	// fifo push
	// ------------------------------------------------------------------------
	assign fifo_data.first = first_pending;
	assign fifo_data.data  = {shift, edge_i.mosi_s};
	assign fifo_wr         = done & ~fifo_full;
	assign overflow_evt    = done & fifo_full;

endmodule

// File: hw/axil_spi_regs.sv
// axi4-lite register block
`timescale 1ns/1ns

module axil_spi_regs import spi_bridge_pkg::*; #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic                            clk_sys,
	input  logic                            rst_n,
	input  logic [3:0]                      awaddr,
	input  logic                            awvalid,
	output logic                            awready,
	input  logic [31:0]                     wdata,
	input  logic                            wvalid,
	output logic                            wready,
	output logic [1:0]                      bresp,
	output logic                            bvalid,
	input  logic                            bready,
	input  logic [3:0]                      araddr,
	input  logic                            arvalid,
	output logic                            arready,
	output logic [31:0]                     rdata,
	output logic [1:0]                      rresp,
	output logic                            rvalid,
	input  logic                            rready,
	output logic                            tx_wr,
	output logic [7:0]                      tx_data,
	input  logic                            tx_full,
	input  logic [$clog2(FIFO_DEPTH+1)-1:0] tx_level,
	output logic                            rx_rd,
	input  rx_entry_t                       rx_entry,
	input  logic                            rx_empty,
	input  logic [$clog2(FIFO_DEPTH+1)-1:0] rx_level,
	input  logic                            underrun_evt,
	input  logic                            overflow_evt
);

	logic wr_acc;
	logic rd_acc;
	logic underrun;
	logic overflow;
	logic clr_underrun;
	logic clr_overflow;

	// ------------------------------------------------------------------------
	// write channel
	// ------------------------------------------------------------------------
	// address and data accepted together for one cycle
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wr_acc <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			wr_acc <= awvalid & wvalid & ~wr_acc & ~bvalid;
			if (wr_acc) begin
				bvalid <= 1'b1;
			end else if (bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	assign awready = wr_acc;
	assign wready  = wr_acc;

	// txdata push, dropped when full
	assign tx_wr   = wr_acc & (awaddr == REG_TXDATA) & ~tx_full;
	assign tx_data = wdata[7:0];

	always_ff @(posedge clk_sys) begin
		if (wr_acc) begin
			case (awaddr)
				REG_TXDATA: bresp <= tx_full ? RESP_SLVERR : RESP_OKAY;
				REG_STATUS: bresp <= RESP_OKAY;
				default:    bresp <= RESP_SLVERR;
			endcase
		end
	end

	// sticky flags, a new event wins over a clear
	assign clr_underrun = wr_acc & (awaddr == REG_STATUS) & wdata[STAT_UNDERRUN];
	assign clr_overflow = wr_acc & (awaddr == REG_STATUS) & wdata[STAT_OVERFLOW];

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			underrun <= 1'b0;
			overflow <= 1'b0;
		end else begin
			underrun <= underrun_evt | (underrun & ~clr_underrun);
			overflow <= overflow_evt | (overflow & ~clr_overflow);
		end
	end

	// ------------------------------------------------------------------------
	// read channel
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rd_acc <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			rd_acc <= arvalid & ~rd_acc & ~rvalid;
			if (rd_acc) begin
				rvalid <= 1'b1;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	assign arready = rd_acc;

	// pop only when there is something to return
	assign rx_rd = rd_acc & (araddr == REG_RXDATA) & ~rx_empty;

	always_ff @(posedge clk_sys) begin
		if (rd_acc) begin
			rresp <= RESP_OKAY;
			case (araddr)
				REG_RXDATA: begin
					if (rx_empty) begin
						rdata <= 32'd0;
					end else begin
						rdata <= {1'b1, 22'd0, rx_entry.first, rx_entry.data};
					end
				end
				REG_STATUS: begin
					rdata <= {14'd0, overflow, underrun, 8'(rx_level), 8'(tx_level)};
				end
				default: begin
					rdata <= 32'd0;
					rresp <= RESP_SLVERR;
				end
			endcase
		end
	end

endmodule

// File: hw/spi_bridge_top.sv
// spi slave bridge top
`timescale 1ns/1ns

module spi_bridge_top import spi_bridge_pkg::*; #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic        spi_csn,
	input  logic        spi_sck,
	input  logic        spi_mosi,
	output logic        spi_miso,
	input  logic [3:0]  awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,
	input  logic [3:0]  araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready
);

	localparam int LW = $clog2(FIFO_DEPTH + 1);

	logic          tx_wr;
	logic [7:0]    tx_wdata;
	logic          tx_rd;
	logic [7:0]    tx_rdata;
	logic          tx_full;
	logic          tx_empty;
	logic [LW-1:0] tx_level;
	logic          rx_wr;
	rx_entry_t     rx_wdata;
	logic          rx_rd;
	rx_entry_t     rx_rdata;
	logic          rx_full;
	logic          rx_empty;
	logic [LW-1:0] rx_level;
	logic          underrun_evt;
	logic          overflow_evt;

	spi_edge_if edge_bus ();

	spi_pin_sync u_pin_sync (
		.clk_sys(clk_sys), .rst_n(rst_n), .spi_csn(spi_csn), .spi_sck(spi_sck),
		.spi_mosi(spi_mosi), .edge_o(edge_bus.src)
	);

	// ------------------------------------------------------------------------
	// transmit path
	// ------------------------------------------------------------------------
	sync_fifo #(.DEPTH(FIFO_DEPTH), .payload_t(logic [7:0])) tx_fifo (
		.clk_sys(clk_sys), .rst_n(rst_n), .wr_en(tx_wr), .wr_data(tx_wdata),
		.rd_en(tx_rd), .rd_data(tx_rdata), .full(tx_full), .empty(tx_empty),
		.level(tx_level)
	);

	spi_tx_serializer u_tx_ser (
		.clk_sys(clk_sys), .rst_n(rst_n), .edge_i(edge_bus.dst), .fifo_data(tx_rdata),
		.fifo_empty(tx_empty), .fifo_rd(tx_rd), .underrun_evt(underrun_evt),
		.spi_miso(spi_miso)
	);

	// ------------------------------------------------------------------------
	// receive path
	// ------------------------------------------------------------------------
	sync_fifo #(.DEPTH(FIFO_DEPTH), .payload_t(rx_entry_t)) rx_fifo (
		.clk_sys(clk_sys), .rst_n(rst_n), .wr_en(rx_wr), .wr_data(rx_wdata),
		.rd_en(rx_rd), .rd_data(rx_rdata), .full(rx_full), .empty(rx_empty),
		.level(rx_level)
	);

	spi_rx_deserializer u_rx_deser (
		.clk_sys(clk_sys), .rst_n(rst_n), .edge_i(edge_bus.dst), .fifo_full(rx_full),
		.fifo_wr(rx_wr), .fifo_data(rx_wdata), .overflow_evt(overflow_evt)
	);

	// host side
	axil_spi_regs #(.FIFO_DEPTH(FIFO_DEPTH)) u_regs (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.tx_wr(tx_wr), .tx_data(tx_wdata), .tx_full(tx_full), .tx_level(tx_level),
		.rx_rd(rx_rd), .rx_entry(rx_rdata), .rx_empty(rx_empty), .rx_level(rx_level),
		.underrun_evt(underrun_evt), .overflow_evt(overflow_evt)
	);

endmodule

// File: testbench/spi_bridge_asserts.sv
// bridge protocol assertions
`timescale 1ns/1ns

module spi_bridge_asserts (
	input logic clk_sys,
	input logic rst_n,
	input logic bvalid,
	input logic bready,
	input logic rvalid,
	input logic rready,
	input logic underrun,
	input logic overflow,
	input logic selected,
	input logic miso
);

	// a response stays up until the master takes it
	bvalid_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

	rvalid_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
		rvalid && !rready |=> rvalid)
		else $error("rvalid dropped before rready");

	miso_known: assert property (@(posedge clk_sys) disable iff (!rst_n)
		selected |-> !$isunknown(miso))
		else $error("miso unknown while selected");

	// sticky flags come out of reset clear
	flags_reset: assert property (@(posedge clk_sys)
		$rose(rst_n) |-> !underrun && !overflow)
		else $error("status flags set right after reset");

endmodule

bind axil_spi_regs spi_bridge_asserts u_regs_chk (
	.clk_sys(clk_sys), .rst_n(rst_n), .bvalid(bvalid), .bready(bready),
	.rvalid(rvalid), .rready(rready), .underrun(underrun), .overflow(overflow),
	.selected(1'b0), .miso(1'b1)
);

bind spi_tx_serializer spi_bridge_asserts u_tx_chk (
	.clk_sys(clk_sys), .rst_n(rst_n), .bvalid(1'b0), .bready(1'b0),
	.rvalid(1'b0), .rready(1'b0), .underrun(1'b0), .overflow(1'b0),
	.selected(edge_i.selected), .miso(spi_miso)
);

// File: testbench/tb_spi_bridge.sv
// spi bridge testbench
`timescale 1ns/1ns

module tb_spi_bridge import spi_bridge_pkg::*; ();

	localparam int DEPTH   = 8;
	localparam int HALF    = 8;
	localparam int TIMEOUT = 50;

	logic        clk_sys;
	logic        rst_n;
	logic        spi_csn;
	logic        spi_sck;
	logic        spi_mosi;
	logic        spi_miso;
	logic [3:0]  awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic [3:0]  araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;

	// model state and result queues
	logic [31:0] rng = 32'ha992_9d6c;
	logic [7:0]  tx_model[$];
	logic [8:0]  rx_model[$];
	logic        model_underrun = 1'b0;
	logic        model_overflow = 1'b0;
	string       name_q[$];
	logic [31:0] got_q[$];
	logic [31:0] want_q[$];
	int          errors = 0;
	int          checks = 0;
	int          tests = 0;
	int          err_mark = 0;

	spi_bridge_top #(.FIFO_DEPTH(DEPTH)) UUT (
		.clk_sys(clk_sys), .rst_n(rst_n), .spi_csn(spi_csn), .spi_sck(spi_sck),
		.spi_mosi(spi_mosi), .spi_miso(spi_miso),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// ------------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------------
	function automatic logic [31:0] next_random();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// byte the master should see next, idle byte when nothing was queued
	function automatic logic [7:0] next_miso_byte();
		if (tx_model.size() == 0) begin
			model_underrun = 1'b1;
			return IDLE_BYTE;
		end
		return tx_model.pop_front();
	endfunction

	function automatic logic [31:0] next_rx_word();
		logic [8:0] e;
		if (rx_model.size() == 0) begin
			return 32'd0;
		end
		e = rx_model.pop_front();
		return {1'b1, 22'd0, e};
	endfunction

	function automatic logic [31:0] status_word();
		return {14'd0, model_overflow, model_underrun,
			8'(rx_model.size()), 8'(tx_model.size())};
	endfunction

	function automatic void store_rx(input logic first, input logic [7:0] data);
		if (rx_model.size() < DEPTH) begin
			rx_model.push_back({first, data});
		end else begin
			model_overflow = 1'b1;
		end
	endfunction

	function automatic void post(input string name, input logic [31:0] got,
		input logic [31:0] want);
		name_q.push_back(name);
		got_q.push_back(got);
		want_q.push_back(want);
	endfunction

	// compare on rising edges, results are posted on falling edges
	initial begin : compare
		string       name;
		logic [31:0] got;
		logic [31:0] want;
		forever begin
			@(posedge clk_sys);
			while (got_q.size() != 0) begin
				name = name_q.pop_front();
				got  = got_q.pop_front();
				want = want_q.pop_front();
				checks++;
				if (got !== want) begin
					errors++;
					$display("mismatch %s: got 0x%h, expected 0x%h", name, got, want);
				end
			end
		end
	end

	// ------------------------------------------------------------------------
	// drivers
	// ------------------------------------------------------------------------
	task automatic cycles(input int n);
		repeat (n) @(posedge clk_sys);
	endtask

	task automatic report_timeout(input string what);
		errors++;
		$display("timeout: %s", what);
	endtask

	// response ready comes one cycle late, so the slave has to hold it
	task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
		input logic [1:0] want_resp);
		int t;
		@(posedge clk_sys);
		awaddr  <= addr;
		wdata   <= data;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		t = 0;
		do begin
			@(negedge clk_sys);
			t++;
		end while (!awready && t < TIMEOUT);
		if (!awready) begin
			report_timeout("write address was never accepted");
		end else begin
			post("wready", 32'(wready), 32'd1);
		end
		@(posedge clk_sys);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		t = 0;
		do begin
			@(negedge clk_sys);
			t++;
		end while (!bvalid && t < TIMEOUT);
		if (!bvalid) begin
			report_timeout("no write response");
		end else begin
			post("bresp", 32'(bresp), 32'(want_resp));
		end
		@(posedge clk_sys);
		bready <= 1'b1;
		@(posedge clk_sys);
		bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [3:0] addr, input logic [31:0] want,
		input string name);
		int t;
		@(posedge clk_sys);
		araddr  <= addr;
		arvalid <= 1'b1;
		t = 0;
		do begin
			@(negedge clk_sys);
			t++;
		end while (!arready && t < TIMEOUT);
		if (!arready) begin
			report_timeout("read address was never accepted");
		end
		@(posedge clk_sys);
		arvalid <= 1'b0;
		t = 0;
		do begin
			@(negedge clk_sys);
			t++;
		end while (!rvalid && t < TIMEOUT);
		if (!rvalid) begin
			report_timeout("no read response");
		end else begin
			post(name, rdata, want);
			post("rresp", 32'(rresp), 32'(RESP_OKAY));
		end
		@(posedge clk_sys);
		rready <= 1'b1;
		@(posedge clk_sys);
		rready <= 1'b0;
	endtask

	task automatic host_push(input logic [7:0] data);
		logic [1:0] want_resp;
		want_resp = RESP_SLVERR;
		if (tx_model.size() < DEPTH) begin
			tx_model.push_back(data);
			want_resp = RESP_OKAY;
		end
		axi_write(REG_TXDATA, {24'd0, data}, want_resp);
	endtask

	task automatic clear_flags(input logic [31:0] bits);
		if (bits[STAT_UNDERRUN]) begin
			model_underrun = 1'b0;
		end
		if (bits[STAT_OVERFLOW]) begin
			model_overflow = 1'b0;
		end
		axi_write(REG_STATUS, bits, RESP_OKAY);
	endtask

	task automatic check_status();
		axi_read(REG_STATUS, status_word(), "status");
	endtask

	task automatic drain_rx(input int n);
		repeat (n) axi_read(REG_RXDATA, next_rx_word(), "rdata");
	endtask

	// one frame, mode 0, msb first, miso sampled on sck rise
	task automatic spi_frame(input int nbytes);
		logic [31:0] rnd;
		logic [7:0]  mosi_byte;
		logic [7:0]  miso_byte;
		logic [7:0]  want;
		int          b;
		int          i;
		@(posedge clk_sys);
		spi_csn <= 1'b0;
		for (b = 0; b < nbytes; b++) begin
			rnd       = next_random();
			mosi_byte = rnd[7:0];
			want      = next_miso_byte();
			store_rx(b == 0, mosi_byte);
			for (i = 7; i >= 0; i--) begin
				spi_mosi <= mosi_byte[i];
				cycles(HALF);
				spi_sck <= 1'b1;
				@(negedge clk_sys);
				miso_byte[i] = spi_miso;
				if (i == 0) begin
					post("spi_miso", 32'(miso_byte), 32'(want));
				end
				cycles(HALF);
				spi_sck <= 1'b0;
			end
		end
		cycles(HALF);
		spi_csn <= 1'b1;
		cycles(HALF);
	endtask

	task automatic end_test(input string name);
		@(posedge clk_sys);
		@(negedge clk_sys);
		tests++;
		$display("test %0d %s: %0d errors", tests, name, errors - err_mark);
		err_mark = errors;
	endtask

	// ------------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------------
	initial begin : main
		logic [31:0] rnd;
		int          left;
		int          len;
		rst_n    <= 1'b0;
		spi_csn  <= 1'b1;
		spi_sck  <= 1'b0;
		spi_mosi <= 1'b0;
		awaddr   <= 4'h0;
		awvalid  <= 1'b0;
		wdata    <= 32'd0;
		wvalid   <= 1'b0;
		bready   <= 1'b0;
		araddr   <= 4'h0;
		arvalid  <= 1'b0;
		rready   <= 1'b0;
		cycles(4);
		rst_n <= 1'b1;
		cycles(2);

		check_status();
		repeat (4) begin
			rnd = next_random();
			host_push(rnd[7:0]);
		end
		spi_frame(4);
		drain_rx(4);
		end_test("transmit order");

		spi_frame(3);
		spi_frame(2);
		drain_rx(6);
		end_test("receive framing");

		clear_flags(32'h0003_0000);
		check_status();
		spi_frame(1);
		check_status();
		clear_flags(32'h0001_0000);
		check_status();
		drain_rx(1);
		end_test("underrun");

		spi_frame(10);
		check_status();
		drain_rx(8);
		clear_flags(32'h0003_0000);
		check_status();
		end_test("overflow");

		repeat (9) begin
			rnd = next_random();
			host_push(rnd[7:0]);
		end
		check_status();
		axi_write(4'hC, 32'd0, RESP_SLVERR);
		spi_frame(8);
		drain_rx(8);
		check_status();
		end_test("write errors");

		// random frame lengths until 32 bytes went both ways
		clear_flags(32'h0003_0000);
		left = 32;
		while (left > 0) begin
			rnd = next_random();
			len = 1 + int'(rnd[2:0]);
			if (len > left) begin
				len = left;
			end
			repeat (len) begin
				rnd = next_random();
				host_push(rnd[7:0]);
			end
			spi_frame(len);
			drain_rx(len);
			left = left - len;
		end
		check_status();
		end_test("full duplex");

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: build.f
hw/spi_bridge_pkg.sv
hw/spi_edge_if.sv
hw/spi_pin_sync.sv
hw/sync_fifo.sv
hw/spi_tx_serializer.sv
hw/spi_rx_deserializer.sv
hw/axil_spi_regs.sv
hw/spi_bridge_top.sv
testbench/spi_bridge_asserts.sv
testbench/tb_spi_bridge.sv

// File: Makefile
SRCS := $(wildcard hw/*.sv testbench/*.sv)

obj_dir/Vtb_spi_bridge: build.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_spi_bridge -f build.f

run: obj_dir/Vtb_spi_bridge
	@out="$$(./obj_dir/Vtb_spi_bridge)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir

.PHONY: run clean
